// File: design/backup_transfer.sv
/*
 * Backup RAM sector sequencer
 * Walks all backup sectors on the SD image in one direction, raising
 * a read or write per sector and stepping on each falling ack
 */
`timescale 1ns/1ps
`include "sms_host_params.svh"

module backup_transfer (
	input  logic                  clk_sys,
	input  logic                  rst,
	input  logic                  bk_start,
	input  logic                  bk_dir_load,
	input  logic                  sd_ack,
	output sms_host_pkg::sd_req_t sd,
	output logic                  bk_busy,
	output logic                  bk_loading
);

	typedef enum logic {
		ST_IDLE,
		ST_XFER
	} bk_state_t;

	localparam logic [`BK_LBA_W-1:0] LAST_LBA = `BK_LBA_W'(`BK_SECTORS - 1);

	bk_state_t state;
	logic      ack_d;

	assign bk_busy = (state == ST_XFER);

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			state      <= ST_IDLE;
			ack_d      <= 1'b0;
			bk_loading <= 1'b0;
			sd         <= '0;
		end else begin
			ack_d <= sd_ack;
			// Request is taken once ack rises
			if (sd_ack & ~ack_d) begin
				sd.rd <= 1'b0;
				sd.wr <= 1'b0;
			end

			case (state)
				ST_IDLE: begin
					if (bk_start) begin
						state      <= ST_XFER;
						bk_loading <= bk_dir_load;
						sd.lba     <= '0;
						sd.rd      <= bk_dir_load;
						sd.wr      <= ~bk_dir_load;
					end
				end
				ST_XFER: begin
					if (ack_d & ~sd_ack) begin  // Sector done
						if (sd.lba == LAST_LBA) begin
							state      <= ST_IDLE;
							bk_loading <= 1'b0;
						end else begin
							sd.lba <= sd.lba + 1'b1;
							sd.rd  <= bk_loading;
							sd.wr  <= ~bk_loading;
						end
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

// File: design/cheat_loader.sv
/*
 * Cheat code loader
 * Gathers sixteen download bytes into one code word and strobes it
 * to the console once the last byte has landed
 */
`timescale 1ns/1ps

module cheat_loader (
	input  logic                      clk_sys,
	input  logic                      rst,
	input  sms_host_pkg::ioctl_bus_t  ioctl,
	input  logic                      code_download,
	output sms_host_pkg::cheat_code_t code,
	output logic                      code_valid
);

	logic       byte_in;
	logic [3:0] slot;
	logic       last_hit;

	assign byte_in = code_download & ioctl.wr;

	// Fields arrive flags first, each one little-endian
	assign slot = ioctl.addr[3:0] ^ 4'd12;

	always_ff @(posedge clk_sys) begin
		if (byte_in)
			code.b[slot] <= ioctl.dout;
	end

	// Strobe follows one cycle after the word is complete
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			last_hit   <= 1'b0;
			code_valid <= 1'b0;
		end else begin
			last_hit   <= byte_in & (ioctl.addr[3:0] == 4'hf);
			code_valid <= last_hit;
		end
	end

endmodule

// File: design/clock_enables.sv
/*
 * Console clock enables
 * Divides clk_sys by a 30-cycle pattern into the sound, VDP, pixel
 * and CPU enables, one cycle wide each
 */
`timescale 1ns/1ps
`include "sms_host_params.svh"

module clock_enables (
	input  logic              clk_sys,
	input  logic              rst,
	output sms_host_pkg::ce_t ce
);

	logic [4:0] cnt;
	logic       cnt_wrap;

	assign cnt_wrap = (cnt == 5'(`CE_PERIOD - 1));

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			cnt <= '0;
			ce  <= '0;
		end else begin
			cnt    <= cnt_wrap ? '0 : cnt + 5'd1;
			ce.sp  <= ~cnt[0];   // High while the count is odd
			ce.vdp <= 1'b0;
			ce.pix <= 1'b0;
			ce.cpu <= 1'b0;
			case (cnt)
				5'd4, 5'd14: ce.vdp <= 1'b1;  // Div 5
				5'd9: begin
					ce.vdp <= 1'b1;
					ce.pix <= 1'b1;
					ce.cpu <= 1'b1;
				end
				5'd19, 5'd29: begin
					ce.vdp <= 1'b1;
					ce.pix <= 1'b1;   // Div 10
				end
				5'd24: begin
					ce.vdp <= 1'b1;
					ce.cpu <= 1'b1;   // Div 15, late phase
				end
				default: ;
			endcase
		end
	end

endmodule

// File: design/core_ctrl.sv
/*
 * Host control
 * Classifies downloads, latches the system kind, holds the console
 * core in reset, and decides when a backup RAM load or save starts
 */
`timescale 1ns/1ps
`include "sms_host_params.svh"

module core_ctrl (
	input  logic                    clk_sys,
	input  logic                    rst,
	input  logic                    user_reset,
	input  sms_host_pkg::ioctl_bus_t ioctl,
	input  logic                    img_mounted,
	input  logic                    img_readonly,
	input  logic [63:0]             img_size,
	input  logic                    osd_open,
	input  logic                    autosave,
	input  logic                    bk_load_req,
	input  logic                    bk_save_req,
	input  logic                    nvram_we,
	input  logic                    bk_busy,
	input  logic                    bk_loading,
	output logic                    cart_download,
	output logic                    code_download,
	output sms_host_pkg::sys_kind_t sys_kind,
	output logic                    core_reset,
	output logic                    bk_ena,
	output logic                    bk_pending,
	output logic                    bk_start,
	output logic                    bk_dir_load
);
	import sms_host_pkg::*;

	logic cart_d;
	logic load_d;
	logic save_d;
	logic load;
	logic save;
	logic load_rise;
	logic save_rise;
	logic cart_end;

	assign cart_download = ioctl.download & ~|ioctl.index[7:2];
	assign code_download = ioctl.download & (ioctl.index == `IDX_CHEAT);

	assign load      = bk_load_req;
	assign save      = bk_save_req | (bk_pending & osd_open & autosave); // Autosave on menu open
	assign load_rise = load & bk_ena & ~load_d;
	assign save_rise = save & bk_ena & ~save_d;
	assign cart_end  = cart_d & ~cart_download;

	// ======================================================================
	// Cartridge state
	// ======================================================================
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			cart_d   <= 1'b0;
			sys_kind <= SYS_SMS;
			bk_ena   <= 1'b0;
		end else begin
			cart_d <= cart_download;
			if (ioctl.wr & cart_download) begin
				if (ioctl.index[4:0] == `IDX_GG)
					sys_kind <= SYS_GG;
				else if (ioctl.index[4:0] == `IDX_SYSE)
					sys_kind <= SYS_SYSE;
				else
					sys_kind <= SYS_SMS;
			end
			if (cart_download & ~cart_d)
				bk_ena <= 1'b0;
			// Save image is mounted by the time the download runs
			if (cart_download & img_mounted & ~img_readonly)
				bk_ena <= 1'b1;
		end
	end

	// ======================================================================
	// Backup launch
	// ======================================================================
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			load_d      <= 1'b0;
			save_d      <= 1'b0;
			bk_pending  <= 1'b0;
			bk_start    <= 1'b0;
			bk_dir_load <= 1'b0;
		end else begin
			load_d   <= load & bk_ena;
			save_d   <= save & bk_ena;
			bk_start <= 1'b0;

			if (bk_ena & ~osd_open & nvram_we)
				bk_pending <= 1'b1;
			else if (bk_busy)
				bk_pending <= 1'b0;

			if (~bk_busy) begin
				if (load_rise | save_rise) begin
					bk_start    <= 1'b1;
					bk_dir_load <= load;
				end
				// Fresh cartridge pulls its saved RAM in
				if (cart_end & |img_size & bk_ena) begin
					bk_start    <= 1'b1;
					bk_dir_load <= 1'b1;
				end
			end
		end
	end

	// Held through downloads and backup loads
	always_ff @(posedge clk_sys) begin
		if (rst)
			core_reset <= 1'b1;
		else
			core_reset <= user_reset | cart_download | bk_loading;
	end

endmodule

// File: design/rom_loader.sv
/*
 * Cartridge ROM loader
 * Streams download bytes to external memory over a toggle handshake,
 * builds the image size masks and maps core reads onto the image,
 * skipping a 512-byte copier header when one is present
 */
`timescale 1ns/1ps
`include "sms_host_params.svh"

module rom_loader (
	input  logic                     clk_sys,
	input  logic                     rst,
	input  sms_host_pkg::ioctl_bus_t ioctl,
	input  logic                     cart_download,
	input  logic                     rom_ack,
	input  logic [`ROM_AW-1:0]       rom_raddr,
	output sms_host_pkg::rom_wr_t    rom_wr,
	output logic                     ioctl_wait,
	output logic [`ROM_AW-1:0]       rom_maddr
);

	logic               cart_d;
	logic               wr_req;
	logic [`ROM_AW-1:0] wr_addr;
	logic [7:0]         wr_data;
	logic [`ROM_AW-1:0] mask;
	logic [`ROM_AW-1:0] mask512;
	logic               hdr;
	logic [`ROM_AW-1:0] dl_addr;
	logic               byte_in;

	assign dl_addr = ioctl.addr[`ROM_AW-1:0];
	assign byte_in = ioctl.wr & cart_download;
	assign rom_wr  = {wr_req, wr_addr, wr_data};

	// ======================================================================
	// Write handshake
	// ======================================================================
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			cart_d     <= 1'b0;
			wr_req     <= 1'b0;
			wr_addr    <= '0;
			ioctl_wait <= 1'b0;
		end else begin
			cart_d <= cart_download;
			if (cart_download & ~cart_d) begin
				wr_addr <= '0;
			end else if (byte_in) begin
				ioctl_wait <= 1'b1;
				wr_req     <= ~wr_req;
			end else if (ioctl_wait && (wr_req == rom_ack)) begin
				ioctl_wait <= 1'b0;     // Memory has taken the byte
				wr_addr    <= wr_addr + 1'b1;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (byte_in)
			wr_data <= ioctl.dout;
	end

	// Size masks grow with every byte written
	always_ff @(posedge clk_sys) begin
		if (byte_in) begin
			if (ioctl.addr == '0)
				mask <= '0;
			else
				mask <= mask | dl_addr;
			if (ioctl.addr == `IOCTL_AW'(`CART_HDR_BYTES))
				mask512 <= '0;
			else
				mask512 <= mask512 | (dl_addr - `ROM_AW'(`CART_HDR_BYTES));
		end
	end

	// Address has moved past the last byte at download end
	always_ff @(posedge clk_sys) begin
		if (rst)
			hdr <= 1'b0;
		else if (cart_d & ~cart_download)
			hdr <= ioctl.addr[9];
	end

	assign rom_maddr = hdr ? (rom_raddr + `ROM_AW'(`CART_HDR_BYTES)) & mask512
	                       : rom_raddr & mask;

endmodule

// File: design/sms_core_host.sv
/*
 * SMS / Game Gear host glue, top level
 * Control block plus ROM loader, cheat loader, clock enables and
 * backup sector sequencer
 */
`timescale 1ns/1ps
`include "sms_host_params.svh"

module sms_core_host (
	input  logic                      clk_sys,
	input  logic                      rst,
	input  logic                      user_reset,
	input  sms_host_pkg::ioctl_bus_t  ioctl,
	input  logic                      rom_ack,
	input  logic [`ROM_AW-1:0]        rom_raddr,
	input  logic                      img_mounted,
	input  logic                      img_readonly,
	input  logic [63:0]               img_size,
	input  logic                      osd_open,
	input  logic                      autosave,
	input  logic                      bk_load_req,
	input  logic                      bk_save_req,
	input  logic                      nvram_we,
	input  logic                      sd_ack,
	output logic                      ioctl_wait,
	output sms_host_pkg::rom_wr_t     rom_wr,
	output logic [`ROM_AW-1:0]        rom_maddr,
	output sms_host_pkg::cheat_code_t code,
	output logic                      code_valid,
	output sms_host_pkg::ce_t         ce,
	output sms_host_pkg::sys_kind_t   sys_kind,
	output logic                      core_reset,
	output logic                      bk_pending,
	output sms_host_pkg::sd_req_t     sd
);

	logic cart_download;
	logic code_download;
	logic bk_start;
	logic bk_dir_load;
	logic bk_busy;
	logic bk_loading;

	core_ctrl i_core_ctrl (
		.clk_sys       (clk_sys),
		.rst           (rst),
		.user_reset    (user_reset),
		.ioctl         (ioctl),
		.img_mounted   (img_mounted),
		.img_readonly  (img_readonly),
		.img_size      (img_size),
		.osd_open      (osd_open),
		.autosave      (autosave),
		.bk_load_req   (bk_load_req),
		.bk_save_req   (bk_save_req),
		.nvram_we      (nvram_we),
		.bk_busy       (bk_busy),
		.bk_loading    (bk_loading),
		.cart_download (cart_download),
		.code_download (code_download),
		.sys_kind      (sys_kind),
		.core_reset    (core_reset),
		.bk_ena        (),
		.bk_pending    (bk_pending),
		.bk_start      (bk_start),
		.bk_dir_load   (bk_dir_load)
	);

	rom_loader i_rom_loader (
		.clk_sys       (clk_sys),
		.rst           (rst),
		.ioctl         (ioctl),
		.cart_download (cart_download),
		.rom_ack       (rom_ack),
		.rom_raddr     (rom_raddr),
		.rom_wr        (rom_wr),
		.ioctl_wait    (ioctl_wait),
		.rom_maddr     (rom_maddr)
	);

	cheat_loader i_cheat_loader (
		.clk_sys       (clk_sys),
		.rst           (rst),
		.ioctl         (ioctl),
		.code_download (code_download),
		.code          (code),
		.code_valid    (code_valid)
	);

	clock_enables i_clock_enables (
		.clk_sys (clk_sys),
		.rst     (rst),
		.ce      (ce)
	);

	backup_transfer i_backup_transfer (
		.clk_sys     (clk_sys),
		.rst         (rst),
		.bk_start    (bk_start),
		.bk_dir_load (bk_dir_load),
		.sd_ack      (sd_ack),
		.sd          (sd),
		.bk_busy     (bk_busy),
		.bk_loading  (bk_loading)
	);

endmodule

// File: design/sms_host_params.svh
/*
 * SMS / Game Gear host glue constants
 * Enable pattern length, backup geometry, cartridge header size,
 * address widths and the download index codes
 */
`ifndef SMS_HOST_PARAMS_SVH
`define SMS_HOST_PARAMS_SVH

// Clock enable pattern, in clk_sys cycles
`define CE_PERIOD       30

// Backup RAM on the SD image
`define BK_SECTORS      64
`define BK_LBA_W        6

// Copier header prepended to some dumps
`define CART_HDR_BYTES  512

// Address widths
`define ROM_AW          22
`define IOCTL_AW        25

// Download indexes
`define IDX_CHEAT       8'hff
`define IDX_GG          5'd2   // Low five bits of a cartridge index
`define IDX_SYSE        5'd3

`endif

// File: design/sms_host_pkg.sv
/*
 * SMS / Game Gear host glue types
 * Download bus, clock enables, SD request, ROM write port and the
 * cheat code word with its field and byte views
 */
`include "sms_host_params.svh"

package sms_host_pkg;

	typedef struct packed {
		logic                 wr;        // One-cycle byte strobe
		logic [`IOCTL_AW-1:0] addr;
		logic [7:0]           dout;
		logic                 download;  // High for the whole transfer
		logic [7:0]           index;
	} ioctl_bus_t;

	typedef struct packed {
		logic cpu;
		logic vdp;
		logic pix;
		logic sp;
	} ce_t;

	typedef enum logic [1:0] {
		SYS_SMS,
		SYS_GG,
		SYS_SYSE
	} sys_kind_t;

	typedef struct packed {
		logic                 rd;
		logic                 wr;
		logic [`BK_LBA_W-1:0] lba;
	} sd_req_t;

	// Flags in the top word
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] addr;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_fields_t;

	typedef union packed {
		cheat_fields_t   f;
		logic [15:0][7:0] b;  // Byte view, b[15] is the top of flags
	} cheat_code_t;

	typedef struct packed {
		logic               req;  // Toggles once per byte
		logic [`ROM_AW-1:0] waddr;
		logic [7:0]         data;
	} rom_wr_t;

endpackage

// File: files.f
+incdir+design
design/sms_host_pkg.sv
design/core_ctrl.sv
design/rom_loader.sv
design/cheat_loader.sv
design/clock_enables.sv
design/backup_transfer.sv
design/sms_core_host.sv
tests/tb_sms_core_host.sv

// File: run_sim.sh
#!/bin/sh
# Compile the testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert \
	--top-module tb_sms_core_host \
	-f files.f \
	--Mdir build -o tb_sms_core_host
./build/tb_sms_core_host

// File: tests/tb_sms_core_host.sv
/*
 * Testbench for the SMS / Game Gear host glue
 * Drives cartridge and cheat downloads, backup save, autosave and
 * auto-load through the top level, with ROM memory and SD ack models
 */
`timescale 1ns/1ps
`include "sms_host_params.svh"

module tb_sms_core_host;
	import sms_host_pkg::*;

	localparam int WAIT_LIMIT = 100;

	logic                 clk_sys = 1'b0;
	logic                 rst;
	logic                 user_reset;
	ioctl_bus_t           ioctl;
	logic                 rom_ack;
	logic [`ROM_AW-1:0]   rom_raddr;
	logic                 img_mounted;
	logic                 img_readonly;
	logic [63:0]          img_size;
	logic                 osd_open;
	logic                 autosave;
	logic                 bk_load_req;
	logic                 bk_save_req;
	logic                 nvram_we;
	logic                 sd_ack;
	logic                 ioctl_wait;
	rom_wr_t              rom_wr;
	logic [`ROM_AW-1:0]   rom_maddr;
	cheat_code_t          code;
	logic                 code_valid;
	ce_t                  ce;
	sys_kind_t            sys_kind;
	logic                 core_reset;
	logic                 bk_pending;
	sd_req_t              sd;

	logic [7:0] img [0:2047];      // Bytes sent by the platform
	logic [7:0] rom_mem [0:2047];  // External ROM contents
	int         rom_writes;

	sms_core_host i_sms_core_host (.*);

	always #2 clk_sys = ~clk_sys;

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("*** TEST FAILED ***");
		$fatal(1, "run stopped at the first failure");
	endtask

	task automatic expect_equal(input string name, input logic [31:0] exp,
	                            input logic [31:0] act);
		assert (act === exp)
		else report_failure($sformatf("error at %0t: %s expected 0x%0h, got 0x%0h",
		                              $time, name, exp, act));
	endtask

	// SD read and write never overlap
	assert property (@(posedge clk_sys) disable iff (rst) !(sd.rd && sd.wr))
	else report_failure("SD read and write were requested together");

	// ======================================================================
	// Memory model and waits
	// ======================================================================
	initial begin : rom_model
		int dly;
		rom_ack    = 1'b0;
		rom_writes = 0;
		forever begin
			@(negedge clk_sys);
			if (rom_wr.req !== rom_ack) begin  // New byte pending
				if (rom_wr.waddr == '0)
					rom_writes = 0;
				expect_equal("rom_wr.waddr", 32'(rom_writes), 32'(rom_wr.waddr));
				rom_mem[rom_wr.waddr[10:0]] = rom_wr.data;
				rom_writes = rom_writes + 1;
				dly = $urandom_range(5, 0);
				repeat (dly) @(negedge clk_sys);
				rom_ack = rom_wr.req;
			end
		end
	end

	task automatic wait_write_done();
		int t;
		t = 0;
		while (ioctl_wait) begin
			if (t == WAIT_LIMIT)
				report_failure("ROM write was not acknowledged in time");
			@(negedge clk_sys);
			t++;
		end
	endtask

	task automatic wait_sd_request();
		int t;
		t = 0;
		while (!(sd.rd || sd.wr)) begin
			if (t == WAIT_LIMIT)
				report_failure("no SD sector request arrived");
			@(negedge clk_sys);
			t++;
		end
	endtask

	task automatic wait_core_release();
		int t;
		t = 0;
		while (core_reset) begin
			if (t == WAIT_LIMIT)
				report_failure("core reset stayed high after the backup load");
			@(negedge clk_sys);
			t++;
		end
	endtask

	// Header images read at offset 512 through the post-header mask
	function automatic logic [`ROM_AW-1:0] mapped_addr(input logic [`ROM_AW-1:0] raddr,
	                                                   input int n);
		logic [`ROM_AW-1:0] m;
		logic [`ROM_AW-1:0] base;
		logic               header;
		m      = '0;
		header = n[9];
		base   = header ? `ROM_AW'(`CART_HDR_BYTES) : '0;
		for (int a = 1; a < n - int'(base); a++)
			m = m | `ROM_AW'(a);
		return (raddr + base) & m;
	endfunction

	// ======================================================================
	// Stimulus tasks
	// ======================================================================
	task automatic download_cart(input logic [7:0] idx, input int n);
		ioctl.index    = idx;
		ioctl.download = 1'b1;
		repeat (2) @(negedge clk_sys);   // Loader sees the rising edge first
		for (int i = 0; i < n; i++) begin
			wait_write_done();
			expect_equal("core_reset", 32'd1, 32'(core_reset));
			img[i]     = 8'($urandom);
			ioctl.addr = `IOCTL_AW'(i);
			ioctl.dout = img[i];
			ioctl.wr   = 1'b1;
			@(negedge clk_sys);
			ioctl.wr   = 1'b0;
			ioctl.addr = `IOCTL_AW'(i + 1);  // Platform address moves on
			expect_equal("ioctl_wait", 32'd1, 32'(ioctl_wait));
		end
		wait_write_done();
		ioctl.download = 1'b0;
		@(negedge clk_sys);
		expect_equal("rom write count", 32'(n), 32'(rom_writes));
		for (int i = 0; i < n; i++)
			expect_equal("rom byte", 32'(img[i]), 32'(rom_mem[i]));
	endtask

	task automatic check_reads(input int n);
		repeat (16) begin
			rom_raddr = `ROM_AW'($urandom);
			@(negedge clk_sys);
			expect_equal("rom_maddr", 32'(mapped_addr(rom_raddr, n)), 32'(rom_maddr));
		end
	endtask

	task automatic load_cheat_code();
		logic [7:0] cb [0:15];
		ioctl.index    = `IDX_CHEAT;
		ioctl.download = 1'b1;
		for (int a = 0; a < 16; a++) begin
			cb[a]      = 8'($urandom);
			ioctl.addr = `IOCTL_AW'(a);
			ioctl.dout = cb[a];
			ioctl.wr   = 1'b1;
			@(negedge clk_sys);
			ioctl.wr   = 1'b0;
			expect_equal("code_valid", 32'd0, 32'(code_valid));
			if (a < 15)
				@(negedge clk_sys);
		end
		@(negedge clk_sys);
		expect_equal("code_valid", 32'd1, 32'(code_valid));
		expect_equal("code.flags", {cb[3], cb[2], cb[1], cb[0]}, code.f.flags);
		expect_equal("code.addr", {cb[7], cb[6], cb[5], cb[4]}, code.f.addr);
		expect_equal("code.compare", {cb[11], cb[10], cb[9], cb[8]}, code.f.compare);
		expect_equal("code.replace", {cb[15], cb[14], cb[13], cb[12]}, code.f.replace);
		@(negedge clk_sys);
		expect_equal("code_valid", 32'd0, 32'(code_valid));
		ioctl.download = 1'b0;
	endtask

	// SD side of one whole backup transfer
	task automatic serve_sectors(input logic load, input logic hold_reset);
		int d;
		for (int s = 0; s < `BK_SECTORS; s++) begin
			wait_sd_request();
			expect_equal("sd.lba", 32'(s), 32'(sd.lba));
			expect_equal("sd.rd", 32'(load), 32'(sd.rd));
			expect_equal("sd.wr", 32'(!load), 32'(sd.wr));
			d = $urandom_range(3, 0);
			repeat (d) @(negedge clk_sys);
			sd_ack = 1'b1;
			@(negedge clk_sys);
			expect_equal("sd.rd", 32'd0, 32'(sd.rd));  // Taken on the ack rise
			expect_equal("sd.wr", 32'd0, 32'(sd.wr));
			d = $urandom_range(3, 0);
			repeat (d) @(negedge clk_sys);
			if (hold_reset)
				expect_equal("core_reset", 32'd1, 32'(core_reset));
			sd_ack = 1'b0;
			@(negedge clk_sys);
		end
		repeat (8) begin
			@(negedge clk_sys);
			expect_equal("sd request after last sector", 32'd0, 32'({sd.rd, sd.wr}));
		end
	endtask

	// Enable pattern over fixed 30-cycle windows
	initial begin : enable_monitor
		int cyc;
		int n_sp;
		int n_vdp;
		int n_pix;
		int n_cpu;
		int last_cpu;
		cyc      = 0;
		n_sp     = 0;
		n_vdp    = 0;
		n_pix    = 0;
		n_cpu    = 0;
		last_cpu = -1;
		@(negedge rst);
		expect_equal("ce", 32'd0, 32'(ce));
		forever begin
			@(negedge clk_sys);
			n_sp  += int'(ce.sp);
			n_vdp += int'(ce.vdp);
			n_pix += int'(ce.pix);
			n_cpu += int'(ce.cpu);
			if (ce.cpu) begin
				if (last_cpu >= 0)
					expect_equal("ce.cpu spacing", 32'd15, 32'(cyc - last_cpu));
				last_cpu = cyc;
			end
			cyc++;
			if (cyc % `CE_PERIOD == 0) begin
				expect_equal("ce.sp per window", 32'd15, 32'(n_sp));
				expect_equal("ce.vdp per window", 32'd6, 32'(n_vdp));
				expect_equal("ce.pix per window", 32'd3, 32'(n_pix));
				expect_equal("ce.cpu per window", 32'd2, 32'(n_cpu));
				n_sp  = 0;
				n_vdp = 0;
				n_pix = 0;
				n_cpu = 0;
			end
		end
	end

	// ======================================================================
	// Main sequence
	// ======================================================================
	initial begin
		void'($urandom(32'h94fa));
		rst          = 1'b1;
		user_reset   = 1'b0;
		ioctl        = '0;
		rom_raddr    = '0;
		img_mounted  = 1'b0;
		img_readonly = 1'b0;
		img_size     = '0;
		osd_open     = 1'b0;
		autosave     = 1'b0;
		bk_load_req  = 1'b0;
		bk_save_req  = 1'b0;
		nvram_we     = 1'b0;
		sd_ack       = 1'b0;
		repeat (16) @(negedge clk_sys);
		rst = 1'b0;
		@(negedge clk_sys);
		img_mounted = 1'b1;                // Writable save image

		download_cart(8'd2, 1536);         // Game Gear dump with header
		expect_equal("sys_kind", 32'(SYS_GG), 32'(sys_kind));
		check_reads(1536);
		download_cart(8'd0, 1024);
		expect_equal("sys_kind", 32'(SYS_SMS), 32'(sys_kind));
		check_reads(1024);

		load_cheat_code();

		bk_save_req = 1'b1;
		@(negedge clk_sys);
		bk_save_req = 1'b0;
		serve_sectors(1'b0, 1'b0);

		nvram_we = 1'b1;
		@(negedge clk_sys);
		nvram_we = 1'b0;
		expect_equal("bk_pending", 32'd1, 32'(bk_pending));
		osd_open = 1'b1;                   // Menu open triggers the autosave
		autosave = 1'b1;
		serve_sectors(1'b0, 1'b0);
		expect_equal("bk_pending", 32'd0, 32'(bk_pending));
		osd_open = 1'b0;
		autosave = 1'b0;

		img_size = 64'd32768;
		download_cart(8'd2, 256);
		serve_sectors(1'b1, 1'b1);
		wait_core_release();

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule
